/* hdl/srambus_axi_pkg.sv */
package srambus_axi_pkg;

	// ====================
	// widths
	// ====================
	localparam int addr_width        = 32;
	localparam int data_width        = 32;
	localparam int strb_width        = 4;
	localparam int match_id_width    = 3;
	localparam int region_code_width = 4;
	localparam int id_width          = match_id_width + region_code_width;
	localparam int resp_width        = 2;

	// second memory window sits 32 KB up
	localparam logic [addr_width-1:0] mem_hi_offset = 32'h0000_8000;

	// top address nibble per region
	localparam logic [3:0] nibble_mem_lo = 4'h0;
	localparam logic [3:0] nibble_mem_hi = 4'h1;
	localparam logic [3:0] nibble_timer  = 4'h2;
	localparam logic [3:0] nibble_uart   = 4'h3;
	localparam logic [3:0] nibble_gpio   = 4'h4;

	// thermometer region codes, low bits of the axi id
	localparam logic [region_code_width-1:0] code_mem   = 4'b0001;
	localparam logic [region_code_width-1:0] code_timer = 4'b0011;
	localparam logic [region_code_width-1:0] code_uart  = 4'b0111;
	localparam logic [region_code_width-1:0] code_gpio  = 4'b1111;
	localparam logic [region_code_width-1:0] code_none  = 4'b0000;

	// single beat, incrementing
	localparam logic [3:0] axi_len_single = 4'd0;
	localparam logic [1:0] burst_incr     = 2'b01;

	// ====================
	// enums
	// ====================
	typedef enum logic [2:0] {
		region_mem,
		region_timer,
		region_uart,
		region_gpio,
		region_none
	} region_e;

	typedef enum logic [1:0] {
		wr_idle,
		wr_addr_data,
		wr_resp
	} wr_state_e;

	typedef enum logic [1:0] {
		rd_idle,
		rd_addr,
		rd_data
	} rd_state_e;

	// ====================
	// bundles
	// ====================
	typedef struct packed {
		logic [addr_width-1:0] addr;
		logic [id_width-1:0]   id;
		logic [2:0]            size;
		logic [3:0]            len;
		logic [1:0]            burst;
	} axi_addr_t;

	typedef struct packed {
		logic [data_width-1:0] data;
		logic [strb_width-1:0] strb;
		logic [id_width-1:0]   id;
	} axi_wdata_t;

	typedef struct packed {
		logic [data_width-1:0] data;
		logic [resp_width-1:0] resp;
		logic [id_width-1:0]   id;
		logic                  last;
	} axi_rresp_t;

	typedef struct packed {
		logic [addr_width-1:0]     addr;
		logic [data_width-1:0]     wdata;
		logic [strb_width-1:0]     wmask;
		logic [2:0]                size;
		logic [match_id_width-1:0] match_id;
	} sram_req_t;

	typedef struct packed {
		logic [addr_width-1:0] addr;
		logic [id_width-1:0]   id;
		logic [2:0]            size;
		logic [data_width-1:0] wdata;
		logic [strb_width-1:0] strb;
	} xfer_cmd_t;

	function automatic logic [region_code_width-1:0] region_code(input region_e region);
		case (region)
			region_mem:   return code_mem;
			region_timer: return code_timer;
			region_uart:  return code_uart;
			region_gpio:  return code_gpio;
			default:      return code_none;
		endcase
	endfunction

endpackage

/* hdl/axi_addr_decode.sv */
module axi_addr_decode
	import srambus_axi_pkg::*;
(
	input  sram_req_t req,
	output xfer_cmd_t cmd,
	output region_e   region
);

	logic [3:0]            nibble;
	logic [addr_width-1:0] addr_cleared;
	logic [addr_width-1:0] addr_offset;

	// ====================
	// region select
	// ====================
	assign nibble = req.addr[addr_width-1 -: 4];

	always_comb begin
		case (nibble)
			nibble_mem_lo,
			nibble_mem_hi: region = region_mem;
			nibble_timer:  region = region_timer;
			nibble_uart:   region = region_uart;
			nibble_gpio:   region = region_gpio;
			default:       region = region_none;
		endcase
	end

	// ====================
	// address remap
	// ====================
	// peripherals see a zero-based address
	assign addr_cleared = {4'h0, req.addr[addr_width-5:0]};

	// upper memory window is shifted into the second half of the ram
	assign addr_offset = (nibble == nibble_mem_hi) ? mem_hi_offset : '0;

	// ====================
	// command
	// ====================
	always_comb begin
		cmd.addr  = addr_cleared + addr_offset;
		// requester tag in the high bits, region code below it
		cmd.id    = {req.match_id, region_code(region)};
		cmd.size  = req.size;
		cmd.wdata = req.wdata;
		cmd.strb  = req.wmask;
	end

endmodule

/* hdl/axi_write_master.sv */
module axi_write_master
	import srambus_axi_pkg::*;
(
	input  logic                  aclk,
	input  logic                  rst_n,
	input  logic                  start,
	input  xfer_cmd_t             cmd,
	input  logic                  resp_ready,
	output axi_addr_t             aw,
	output logic                  awvalid,
	input  logic                  awready,
	output axi_wdata_t            w,
	output logic                  wvalid,
	output logic                  wlast,
	input  logic                  wready,
	input  logic [resp_width-1:0] bresp,
	input  logic [id_width-1:0]   bid,
	input  logic                  bvalid,
	output logic                  bready,
	output logic                  addr_ok,
	output logic                  data_ok,
	output logic                  writing,
	output logic [addr_width-1:0] last_write_address
);

	wr_state_e  state;
	logic       accept;
	logic       aw_done;
	logic       w_done;
	logic       aw_hs;
	logic       w_hs;
	axi_addr_t  aw_q;
	axi_wdata_t w_q;

	assign accept = (state == wr_idle) && start;

	// ====================
	// channel handshakes
	// ====================
	// each channel drops its valid once its own handshake is done
	assign awvalid = (state == wr_addr_data) && !aw_done;
	assign wvalid  = (state == wr_addr_data) && !w_done;
	assign wlast   = wvalid;

	assign aw_hs = awvalid && awready;
	assign w_hs  = wvalid && wready;

	// fires on whichever of aw and w finishes second
	assign addr_ok = (state == wr_addr_data) && (aw_done || aw_hs) && (w_done || w_hs);

	assign bready  = (state == wr_resp) && resp_ready;
	assign data_ok = bvalid && bready;
	assign writing = (state != wr_idle);

	assign aw = aw_q;
	assign w  = w_q;

	// ====================
	// control
	// ====================
	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			state              <= wr_idle;
			aw_done            <= 1'b0;
			w_done             <= 1'b0;
			last_write_address <= '0;
		end else begin
			case (state)
				wr_idle: begin
					if (start) begin
						state              <= wr_addr_data;
						aw_done            <= 1'b0;
						w_done             <= 1'b0;
						last_write_address <= cmd.addr;
					end
				end
				wr_addr_data: begin
					if (addr_ok) begin
						state   <= wr_resp;
						aw_done <= 1'b0;
						w_done  <= 1'b0;
					end else begin
						if (aw_hs)
							aw_done <= 1'b1;
						if (w_hs)
							w_done <= 1'b1;
					end
				end
				wr_resp: begin
					if (data_ok)
						state <= wr_idle;
				end
				default: state <= wr_idle;
			endcase
		end
	end

	// payload captured once per write
	always_ff @(posedge aclk) begin
		if (accept) begin
			aw_q <= '{addr: cmd.addr, id: cmd.id, size: cmd.size,
				len: axi_len_single, burst: burst_incr};
			w_q  <= '{data: cmd.wdata, strb: cmd.strb, id: cmd.id};
		end
	end

	// ====================
	// checks
	// ====================
	aw_held: assert property (@(posedge aclk) disable iff (!rst_n)
		awvalid && !awready |=> awvalid && $stable(aw));

	start_when_idle: assert property (@(posedge aclk) disable iff (!rst_n)
		start |-> state == wr_idle);

	// response belongs to the write in flight
	b_matches: assert property (@(posedge aclk) disable iff (!rst_n)
		data_ok |-> bid == aw_q.id && !$isunknown(bresp));

endmodule

/* hdl/axi_read_master.sv */
module axi_read_master
	import srambus_axi_pkg::*;
(
	input  logic                  aclk,
	input  logic                  rst_n,
	input  logic                  start,
	input  xfer_cmd_t             cmd,
	input  logic                  resp_ready,
	output axi_addr_t             ar,
	output logic                  arvalid,
	input  logic                  arready,
	input  axi_rresp_t            r,
	input  logic                  rvalid,
	output logic                  rready,
	output logic                  addr_ok,
	output logic                  data_ok,
	output logic [data_width-1:0] rdata
);

	rd_state_e state;
	logic      accept;
	logic      ar_hs;
	axi_addr_t ar_q;

	assign accept = (state == rd_idle) && start;

	// ====================
	// handshakes
	// ====================
	assign arvalid = (state == rd_addr);
	assign ar_hs   = arvalid && arready;
	assign addr_ok = ar_hs;

	// requester readiness is the only throttle on r
	assign rready  = (state == rd_data) && resp_ready;
	assign data_ok = rvalid && rready;
	assign rdata   = r.data;

	assign ar = ar_q;

	// ====================
	// control
	// ====================
	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			state <= rd_idle;
		end else begin
			case (state)
				rd_idle: begin
					if (start)
						state <= rd_addr;
				end
				rd_addr: begin
					if (ar_hs)
						state <= rd_data;
				end
				rd_data: begin
					// single beat, done on first accepted r
					if (data_ok)
						state <= rd_idle;
				end
				default: state <= rd_idle;
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (accept) begin
			ar_q <= '{addr: cmd.addr, id: cmd.id, size: cmd.size,
				len: axi_len_single, burst: burst_incr};
		end
	end

	// ====================
	// checks
	// ====================
	ar_held: assert property (@(posedge aclk) disable iff (!rst_n)
		arvalid && !arready |=> arvalid && $stable(ar));

	r_single_beat: assert property (@(posedge aclk) disable iff (!rst_n)
		data_ok |-> r.last);

	// slave answers with the id we issued
	r_matches: assert property (@(posedge aclk) disable iff (!rst_n)
		data_ok |-> r.id == ar_q.id && !$isunknown(r.resp));

endmodule

/* hdl/srambus2axi.sv */
module srambus2axi
	import srambus_axi_pkg::*;
(
	input  logic                  aclk,
	input  logic                  rst_n,
	// sram-style bus
	input  logic                  mem_req,
	input  logic                  mem_ren,
	input  logic                  mem_wen,
	input  sram_req_t             mem_req_bus,
	input  logic                  mem_data_resp,
	output logic                  mem_addr_ok,
	output logic                  mem_data_ok,
	output logic [data_width-1:0] mem_rdata,
	output logic                  writing,
	output logic [addr_width-1:0] last_write_address,
	// axi write
	output axi_addr_t             aw,
	output logic                  awvalid,
	input  logic                  awready,
	output axi_wdata_t            w,
	output logic                  wvalid,
	output logic                  wlast,
	input  logic                  wready,
	input  logic [resp_width-1:0] bresp,
	input  logic [id_width-1:0]   bid,
	input  logic                  bvalid,
	output logic                  bready,
	// axi read
	output axi_addr_t             ar,
	output logic                  arvalid,
	input  logic                  arready,
	input  axi_rresp_t            r,
	input  logic                  rvalid,
	output logic                  rready
);

	xfer_cmd_t cmd;
	logic      start_wr;
	logic      start_rd;
	logic      wr_addr_ok;
	logic      wr_data_ok;
	logic      rd_addr_ok;
	logic      rd_data_ok;

	// a held write is not re-accepted while its own transfer is running
	assign start_wr = mem_req && mem_wen && !writing;
	assign start_rd = mem_req && mem_ren && !mem_wen;

	// each pulse comes from exactly one master
	assign mem_addr_ok = wr_addr_ok || rd_addr_ok;
	assign mem_data_ok = wr_data_ok || rd_data_ok;

	axi_addr_decode u_addr_decode (
		.req    (mem_req_bus),
		.cmd    (cmd),
		.region ()
	);

	axi_write_master u_write_master (
		.aclk               (aclk),
		.rst_n              (rst_n),
		.start              (start_wr),
		.cmd                (cmd),
		.resp_ready         (mem_data_resp),
		.aw                 (aw),
		.awvalid            (awvalid),
		.awready            (awready),
		.w                  (w),
		.wvalid             (wvalid),
		.wlast              (wlast),
		.wready             (wready),
		.bresp              (bresp),
		.bid                (bid),
		.bvalid             (bvalid),
		.bready             (bready),
		.addr_ok            (wr_addr_ok),
		.data_ok            (wr_data_ok),
		.writing            (writing),
		.last_write_address (last_write_address)
	);

	axi_read_master u_read_master (
		.aclk       (aclk),
		.rst_n      (rst_n),
		.start      (start_rd),
		.cmd        (cmd),
		.resp_ready (mem_data_resp),
		.ar         (ar),
		.arvalid    (arvalid),
		.arready    (arready),
		.r          (r),
		.rvalid     (rvalid),
		.rready     (rready),
		.addr_ok    (rd_addr_ok),
		.data_ok    (rd_data_ok),
		.rdata      (mem_rdata)
	);

	// ====================
	// checks
	// ====================
	// the bus only offers one address at a time
	one_addr_ok: assert property (@(posedge aclk) disable iff (!rst_n)
		!(wr_addr_ok && rd_addr_ok));

endmodule

/* tb/axi_slave_model.sv */
module axi_slave_model
	import srambus_axi_pkg::*;
(
	input  logic                  aclk,
	input  logic                  rst_n,
	input  axi_addr_t             aw,
	input  logic                  awvalid,
	output logic                  awready,
	input  axi_wdata_t            w,
	input  logic                  wvalid,
	output logic                  wready,
	output logic [resp_width-1:0] bresp,
	output logic [id_width-1:0]   bid,
	output logic                  bvalid,
	input  logic                  bready,
	input  axi_addr_t             ar,
	input  logic                  arvalid,
	output logic                  arready,
	output axi_rresp_t            r,
	output logic                  rvalid,
	input  logic                  rready
);

	integer                seed = 42882;
	logic [data_width-1:0] mem [logic [addr_width-1:0]];
	logic [1:0]            aw_cnt, w_cnt, b_cnt, ar_cnt, r_cnt;
	logic                  have_aw, have_w, have_ar;
	axi_addr_t             aw_q, ar_q;
	axi_wdata_t            w_q;

	function automatic logic [1:0] rand_delay();
		return $unsigned($random(seed)) % 4;
	endfunction

	// unwritten words read back as a pattern of their own address
	function automatic logic [data_width-1:0] read_word(input logic [addr_width-1:0] a);
		return mem.exists(a >> 2) ? mem[a >> 2] : (a ^ 32'h5a5a_a5a5);
	endfunction

	task automatic store_word(input logic [addr_width-1:0] a, input axi_wdata_t wd);
		logic [data_width-1:0] word;
		word = read_word(a);
		for (int i = 0; i < strb_width; i++)
			if (wd.strb[i])
				word[8*i +: 8] = wd.data[8*i +: 8];
		mem[a >> 2] = word;
	endtask

	// ====================
	// write side
	// ====================
	always @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
			bresp   <= '0;
			bid     <= '0;
			have_aw <= 1'b0;
			have_w  <= 1'b0;
			aw_cnt  <= '0;
			w_cnt   <= '0;
			b_cnt   <= '0;
		end else begin
			if (awvalid && awready) begin
				awready <= 1'b0;
				aw_q    <= aw;
				have_aw <= 1'b1;
				aw_cnt  <= rand_delay();
			end else if (awvalid && !have_aw) begin
				if (aw_cnt == 0)
					awready <= 1'b1;
				else
					aw_cnt <= aw_cnt - 1;
			end
			if (wvalid && wready) begin
				wready <= 1'b0;
				w_q    <= w;
				have_w <= 1'b1;
				w_cnt  <= rand_delay();
			end else if (wvalid && !have_w) begin
				if (w_cnt == 0)
					wready <= 1'b1;
				else
					w_cnt <= w_cnt - 1;
			end
			if (have_aw && have_w && !bvalid) begin
				if (b_cnt == 0) begin
					store_word(aw_q.addr, w_q);
					bvalid  <= 1'b1;
					bresp   <= 2'b00;
					bid     <= aw_q.id;
					have_aw <= 1'b0;
					have_w  <= 1'b0;
					b_cnt   <= rand_delay();
				end else begin
					b_cnt <= b_cnt - 1;
				end
			end
			if (bvalid && bready)
				bvalid <= 1'b0;
		end
	end

	// ====================
	// read side
	// ====================
	always @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
			r       <= '0;
			have_ar <= 1'b0;
			ar_cnt  <= '0;
			r_cnt   <= '0;
		end else begin
			if (arvalid && arready) begin
				arready <= 1'b0;
				ar_q    <= ar;
				have_ar <= 1'b1;
				ar_cnt  <= rand_delay();
			end else if (arvalid && !have_ar) begin
				if (ar_cnt == 0)
					arready <= 1'b1;
				else
					ar_cnt <= ar_cnt - 1;
			end
			if (have_ar && !rvalid) begin
				if (r_cnt == 0) begin
					rvalid  <= 1'b1;
					r       <= '{data: read_word(ar_q.addr), resp: 2'b00, id: ar_q.id, last: 1'b1};
					have_ar <= 1'b0;
					r_cnt   <= rand_delay();
				end else begin
					r_cnt <= r_cnt - 1;
				end
			end
			if (rvalid && rready)
				rvalid <= 1'b0;
		end
	end

endmodule

/* tb/tb_srambus2axi.sv */
module tb_srambus2axi
	import srambus_axi_pkg::*;
;

	typedef struct packed {
		logic                      is_write;
		logic [addr_width-1:0]     addr;
		logic [data_width-1:0]     wdata;
		logic [strb_width-1:0]     wmask;
		logic [2:0]                size;
		logic [match_id_width-1:0] match_id;
		logic [3:0]                hold;
		logic [addr_width-1:0]     exp_addr;
		logic [id_width-1:0]       exp_id;
		logic [data_width-1:0]     exp_rdata;
	} entry_t;

	localparam int num_entries = 11;
	localparam int wait_limit  = 200;

	// op, bus addr, wdata, mask, size, match id, hold, remapped addr, id, rdata
	localparam entry_t table_q [num_entries] = '{
		'{1'b1, 32'h0000_0100, 32'h1122_3344, 4'hf, 3'd2, 3'd1, 4'd0, 32'h0000_0100, 7'h11, 32'h0},
		'{1'b0, 32'h0000_0100, 32'h0,         4'h0, 3'd2, 3'd2, 4'd2, 32'h0000_0100, 7'h21, 32'h1122_3344},
		'{1'b1, 32'h1000_0040, 32'hcafe_f00d, 4'hf, 3'd2, 3'd3, 4'd0, 32'h0000_8040, 7'h31, 32'h0},
		'{1'b0, 32'h1000_0040, 32'h0,         4'h0, 3'd2, 3'd0, 4'd3, 32'h0000_8040, 7'h01, 32'hcafe_f00d},
		'{1'b1, 32'h2000_0010, 32'h0bad_beef, 4'hf, 3'd2, 3'd4, 4'd1, 32'h0000_0010, 7'h43, 32'h0},
		'{1'b1, 32'h3000_0020, 32'h0000_00aa, 4'h1, 3'd0, 3'd5, 4'd0, 32'h0000_0020, 7'h57, 32'h0},
		'{1'b1, 32'h4000_0030, 32'h1234_5678, 4'hf, 3'd2, 3'd6, 4'd0, 32'h0000_0030, 7'h6f, 32'h0},
		'{1'b1, 32'h0000_0100, 32'haabb_ccdd, 4'h5, 3'd2, 3'd7, 4'd2, 32'h0000_0100, 7'h71, 32'h0},
		'{1'b0, 32'h0000_0100, 32'h0,         4'h0, 3'd2, 3'd1, 4'd0, 32'h0000_0100, 7'h11, 32'h11bb_33dd},
		'{1'b1, 32'h9000_0050, 32'h55aa_55aa, 4'hf, 3'd2, 3'd2, 4'd1, 32'h0000_0050, 7'h20, 32'h0},
		'{1'b0, 32'h9000_0050, 32'h0,         4'h0, 3'd2, 3'd3, 4'd0, 32'h0000_0050, 7'h30, 32'h55aa_55aa}
	};

	logic                  aclk, rst_n;
	logic                  mem_req, mem_ren, mem_wen, mem_data_resp;
	sram_req_t             mem_req_bus;
	logic                  mem_addr_ok, mem_data_ok, writing;
	logic [data_width-1:0] mem_rdata;
	logic [addr_width-1:0] last_write_address;
	axi_addr_t             aw, ar, aw_seen, ar_seen;
	axi_wdata_t            w, w_seen;
	axi_rresp_t            r;
	logic                  awvalid, awready, wvalid, wlast, wready;
	logic                  bvalid, bready, arvalid, arready, rvalid, rready;
	logic [resp_width-1:0] bresp;
	logic [id_width-1:0]   bid;
	int                    data_ok_count;
	logic [data_width-1:0] shadow [logic [addr_width-1:0]];

	srambus2axi u_srambus2axi (.*);

	axi_slave_model u_slave (.*);

	initial begin
		aclk = 1'b0;
		forever #5 aclk = ~aclk;
	end

	// ====================
	// monitor
	// ====================
	initial data_ok_count = 0;

	always @(posedge aclk) begin
		if (awvalid && awready)
			aw_seen <= aw;
		if (wvalid && wready) begin
			w_seen <= w;
			if (!wlast)
				report_failure("wlast was low on an accepted write beat");
		end
		if (arvalid && arready)
			ar_seen <= ar;
		if (mem_data_ok)
			data_ok_count <= data_ok_count + 1;
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_addr(input string name, input axi_addr_t got, input axi_addr_t exp);
		if (got !== exp)
			report_failure($sformatf("ERROR at %0t: %s expected %h got %h", $time, name, exp, got));
	endtask

	task automatic check_id(input string name, input logic [id_width-1:0] got,
		input logic [id_width-1:0] exp);
		if (got !== exp)
			report_failure($sformatf("ERROR at %0t: %s expected %h got %h", $time, name, exp, got));
	endtask

	task automatic check_data(input string name, input logic [data_width-1:0] got,
		input logic [data_width-1:0] exp);
		if (got !== exp)
			report_failure($sformatf("ERROR at %0t: %s expected %h got %h", $time, name, exp, got));
	endtask

	task automatic check_writing(input logic exp);
		if (writing !== exp)
			report_failure($sformatf("ERROR at %0t: writing expected %b got %b", $time, exp, writing));
	endtask

	// ====================
	// one table entry
	// ====================
	task automatic run_entry(input entry_t e);
		int        cycles;
		axi_addr_t exp_bundle;
		exp_bundle = '{addr: e.exp_addr, id: e.exp_id, size: e.size, len: 4'd0, burst: 2'b01};
		@(negedge aclk);
		mem_req       = 1'b1;
		mem_wen       = e.is_write;
		mem_ren       = !e.is_write;
		mem_req_bus   = '{addr: e.addr, wdata: e.wdata, wmask: e.wmask, size: e.size,
			match_id: e.match_id};
		mem_data_resp = (e.hold == 0);
		@(posedge aclk);
		check_writing(1'b0);
		cycles = 0;
		do begin
			@(posedge aclk);
			check_writing(e.is_write);
			cycles++;
			if (cycles > wait_limit)
				report_failure("timeout waiting for mem_addr_ok");
		end while (!mem_addr_ok);
		@(negedge aclk);
		mem_req = 1'b0;
		// response held off by the requester
		for (int i = 0; i < e.hold; i++) begin
			@(posedge aclk);
			if (mem_data_ok)
				report_failure("mem_data_ok pulsed while mem_data_resp was low");
			@(negedge aclk);
		end
		mem_data_resp = 1'b1;
		cycles = 0;
		do begin
			@(posedge aclk);
			check_writing(e.is_write);
			cycles++;
			if (cycles > wait_limit)
				report_failure("timeout waiting for mem_data_ok");
		end while (!mem_data_ok);
		if (e.is_write) begin
			check_addr("aw", aw_seen, exp_bundle);
			check_id("w.id", w_seen.id, e.exp_id);
			check_data("w.data", w_seen.data, e.wdata);
			check_data("last_write_address", last_write_address, e.exp_addr);
		end else begin
			check_addr("ar", ar_seen, exp_bundle);
			check_data("mem_rdata", mem_rdata, e.exp_rdata);
			check_data("mem_rdata vs shadow", mem_rdata, shadow[e.exp_addr]);
		end
		@(posedge aclk);
		check_writing(1'b0);
	endtask

	task automatic update_shadow(input entry_t e);
		logic [data_width-1:0] word;
		word = shadow.exists(e.exp_addr) ? shadow[e.exp_addr] : '0;
		for (int i = 0; i < strb_width; i++)
			if (e.wmask[i])
				word[8*i +: 8] = e.wdata[8*i +: 8];
		shadow[e.exp_addr] = word;
	endtask

	initial begin
		rst_n         = 1'b0;
		mem_req       = 1'b0;
		mem_ren       = 1'b0;
		mem_wen       = 1'b0;
		mem_data_resp = 1'b0;
		mem_req_bus   = '0;
		repeat (4) @(posedge aclk);
		@(negedge aclk);
		rst_n = 1'b1;
		for (int i = 0; i < num_entries; i++) begin
			if (table_q[i].is_write)
				update_shadow(table_q[i]);
			run_entry(table_q[i]);
		end
		@(posedge aclk);
		if (data_ok_count != num_entries)
			report_failure($sformatf("saw %0d data_ok pulses for %0d transfers",
				data_ok_count, num_entries));
		else begin
			$display("No errors");
			$finish;
		end
	end

endmodule

/* filelist.f */
hdl/srambus_axi_pkg.sv
hdl/axi_addr_decode.sv
hdl/axi_write_master.sv
hdl/axi_read_master.sv
hdl/srambus2axi.sv
tb/axi_slave_model.sv
tb/tb_srambus2axi.sv
